// File: src/uart_rx_params.svh
// ******************************
// UART receiver constants
// Widths, APB register map and reset values
// ******************************
`ifndef UART_RX_PARAMS_SVH
`define UART_RX_PARAMS_SVH

// Bus and field widths
`define UART_RX_ADDR_W   3
`define UART_RX_DATA_W   8
`define UART_RX_PERIOD_W 14
`define UART_RX_SIZE_W   4

// APB register map
`define UART_RX_ADDR_DATA_SR   3'd0
`define UART_RX_ADDR_ERROR_SR  3'd1
`define UART_RX_ADDR_PERIOD_LO 3'd2
`define UART_RX_ADDR_PERIOD_HI 3'd3
`define UART_RX_ADDR_DATA_SIZE 3'd4
`define UART_RX_ADDR_RX_DATA   3'd6

// Configuration after reset
`define UART_RX_RESET_PERIOD 14'd10
`define UART_RX_RESET_SIZE   4'd8
// Legal frame widths
`define UART_RX_MIN_SIZE 4'd5
`define UART_RX_MAX_SIZE 4'd8

`endif

// File: src/uart_rx_pkg.sv
// ******************************
// UART receiver shared types
// Frame FSM states and datapath widths
// ******************************
`include "uart_rx_params.svh"

package uart_rx_pkg;

  // ******************************
  // Frame FSM
  // ******************************
  // Idle waits for a falling edge, start confirms it at mid-bit
  typedef enum logic [1:0]
  {
    ST_IDLE  = 2'd0,
    ST_START = 2'd1,
    ST_DATA  = 2'd2,
    ST_STOP  = 2'd3
  } rx_state_t;

  // ******************************
  // Datapath types
  // ******************************
  // Bit period in clock cycles, 10..16383 in use
  typedef logic [`UART_RX_PERIOD_W-1:0] rx_period_t;
  // Number of data bits per frame
  typedef logic [`UART_RX_SIZE_W-1:0]   rx_size_t;
  // Received word and APB data
  typedef logic [`UART_RX_DATA_W-1:0]   rx_word_t;

endpackage

// File: src/rx_bit_timer.sv
// ******************************
// Receive bit timer
// Synchronizes the serial line, flags the start edge
// and strobes sample at the middle of each bit
// ******************************
`timescale 1ns/1ps

module rx_bit_timer
(
  input  logic                   tb_clk,
  input  logic                   rst_n,
  input  logic                   serial_in,
  input  logic                   timer_run,
  input  uart_rx_pkg::rx_period_t bit_period,
  output logic                   line,
  output logic                   start_edge,
  output logic                   sample
);

  import uart_rx_pkg::*;

  logic       sync_ff;
  logic       line_d;
  rx_period_t cnt;
  rx_period_t half_period;
  rx_period_t target;
  logic       half_done;

  // ******************************
  // Line synchronizer
  // ******************************
  // Two flops, then one more for edge detection
  // Idle line is high, so reset to 1 avoids a fake start
  always_ff @(posedge tb_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_ff <= 1'b1;
      line    <= 1'b1;
      line_d  <= 1'b1;
    end
    else
    begin
      sync_ff <= serial_in;
      line    <= sync_ff;
      line_d  <= line;
    end
  end

  // High for one cycle after line drops
  assign start_edge = line_d & ~line;

  // ******************************
  // Bit period counter
  // ******************************
  // First strobe at half a period, then every full period
  assign half_period = bit_period >> 1;
  assign target      = half_done ? bit_period : half_period;
  assign sample      = timer_run & (cnt == target - 1'b1);

  always_ff @(posedge tb_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt       <= '0;
      half_done <= 1'b0;
    end
    else if (!timer_run)
    begin
      // Frame over or rejected
      cnt       <= '0;
      half_done <= 1'b0;
    end
    else if (sample)
    begin
      cnt       <= '0;
      half_done <= 1'b1;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// File: src/rx_frame_ctrl.sv
// ******************************
// Receive frame controller
// Confirms the start bit, shifts data LSB first
// and checks the stop bit
// ******************************
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module rx_frame_ctrl
(
  input  logic                 tb_clk,
  input  logic                 rst_n,
  input  logic                 line,
  input  logic                 start_edge,
  input  logic                 sample,
  input  uart_rx_pkg::rx_size_t data_size,
  output logic                 timer_run,
  output logic                 frame_done,
  output uart_rx_pkg::rx_word_t frame_data,
  output logic                 frame_err
);

  import uart_rx_pkg::*;

  rx_state_t state;
  rx_size_t  bit_cnt;
  rx_size_t  frame_size;
  rx_word_t  data_q;

  // Timer runs for the whole frame
  assign timer_run  = (state != ST_IDLE);
  assign frame_data = data_q;

  // ******************************
  // Frame FSM and shift register
  // ******************************
  always_ff @(posedge tb_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ST_IDLE;
      bit_cnt    <= '0;
      frame_size <= `UART_RX_RESET_SIZE;
      data_q     <= '0;
      frame_done <= 1'b0;
      frame_err  <= 1'b0;
    end
    else
    begin
      // Single-cycle pulse
      frame_done <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (start_edge)
          begin
            // Size is frozen for the whole frame
            state      <= ST_START;
            frame_size <= data_size;
          end
        end
        ST_START:
        begin
          if (sample)
          begin
            // Line back high at mid-bit means a glitch
            if (line)
            begin
              state <= ST_IDLE;
            end
            else
            begin
              state   <= ST_DATA;
              bit_cnt <= '0;
              // Upper bits stay zero for short frames
              data_q  <= '0;
            end
          end
        end
        ST_DATA:
        begin
          if (sample)
          begin
            // LSB arrives first so the word stays right-aligned
            data_q[bit_cnt[2:0]] <= line;
            bit_cnt              <= bit_cnt + 1'b1;
            if (bit_cnt == frame_size - 1'b1)
            begin
              state <= ST_STOP;
            end
          end
        end
        ST_STOP:
        begin
          if (sample)
          begin
            // Data handed over even with a low stop bit
            frame_err  <= ~line;
            frame_done <= 1'b1;
            state      <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/apb_rx_regs.sv
// ******************************
// APB register block
// Period and size config, one-word receive buffer
// and status and error flags
// ******************************
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module apb_rx_regs
(
  input  logic                         tb_clk,
  input  logic                         rst_n,
  input  logic                         psel,
  input  logic [`UART_RX_ADDR_W-1:0]   paddr,
  input  logic                         penable,
  input  logic                         pwrite,
  input  uart_rx_pkg::rx_word_t         pwdata,
  output uart_rx_pkg::rx_word_t         prdata,
  output logic                         pslverr,
  input  logic                         frame_done,
  input  uart_rx_pkg::rx_word_t         frame_data,
  input  logic                         frame_err,
  output uart_rx_pkg::rx_period_t       bit_period,
  output uart_rx_pkg::rx_size_t         data_size
);

  import uart_rx_pkg::*;

  logic       access;
  logic       wr_en;
  logic       rd_en;
  logic       addr_ok;
  logic       rd_clear;
  rx_word_t   rd_mux;
  rx_word_t   rx_data;
  rx_size_t   size_wr;
  logic       data_ready;
  logic       overrun;
  logic       framing_err;

  // ******************************
  // Access decode
  // ******************************
  // APB access phase without wait states
  assign access = psel & penable;
  assign wr_en  = access & pwrite;
  assign rd_en  = access & ~pwrite;
  // Holes in the map at 5 and 7
  assign addr_ok = (paddr != 3'd5) && (paddr != 3'd7);
  assign pslverr = access & ~addr_ok;
  // Reading the data word clears all flags
  assign rd_clear = rd_en && (paddr == `UART_RX_ADDR_RX_DATA);

  // Data size kept inside 5..8
  always_comb
  begin
    if (pwdata < `UART_RX_MIN_SIZE)
      size_wr = `UART_RX_MIN_SIZE;
    else if (pwdata > `UART_RX_MAX_SIZE)
      size_wr = `UART_RX_MAX_SIZE;
    else
      size_wr = pwdata[`UART_RX_SIZE_W-1:0];
  end

  // ******************************
  // Config registers
  // ******************************
  always_ff @(posedge tb_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_period <= `UART_RX_RESET_PERIOD;
      data_size  <= `UART_RX_RESET_SIZE;
    end
    else if (wr_en)
    begin
      // Writes to status and data addresses are dropped
      case (paddr)
        `UART_RX_ADDR_PERIOD_LO: bit_period[`UART_RX_DATA_W-1:0] <= pwdata;
        `UART_RX_ADDR_PERIOD_HI:
          bit_period[`UART_RX_PERIOD_W-1:`UART_RX_DATA_W] <=
            pwdata[`UART_RX_PERIOD_W-`UART_RX_DATA_W-1:0];
        `UART_RX_ADDR_DATA_SIZE: data_size <= size_wr;
        default:
        begin
        end
      endcase
    end
  end

  // ******************************
  // Receive buffer and flags
  // ******************************
  always_ff @(posedge tb_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_data     <= '0;
      data_ready  <= 1'b0;
      overrun     <= 1'b0;
      framing_err <= 1'b0;
    end
    else if (frame_done)
    begin
      // New word wins over a read in the same cycle
      rx_data     <= frame_data;
      data_ready  <= 1'b1;
      // Unread word lost
      overrun     <= (overrun | data_ready) & ~rd_clear;
      framing_err <= (framing_err & ~rd_clear) | frame_err;
    end
    else if (rd_clear)
    begin
      data_ready  <= 1'b0;
      overrun     <= 1'b0;
      framing_err <= 1'b0;
    end
  end

  // ******************************
  // Read mux
  // ******************************
  always_comb
  begin
    case (paddr)
      `UART_RX_ADDR_DATA_SR:   rd_mux = rx_word_t'(data_ready);
      `UART_RX_ADDR_ERROR_SR:  rd_mux = rx_word_t'({overrun, framing_err});
      `UART_RX_ADDR_PERIOD_LO: rd_mux = bit_period[`UART_RX_DATA_W-1:0];
      `UART_RX_ADDR_PERIOD_HI:
        rd_mux = rx_word_t'(bit_period[`UART_RX_PERIOD_W-1:`UART_RX_DATA_W]);
      `UART_RX_ADDR_DATA_SIZE: rd_mux = rx_word_t'(data_size);
      `UART_RX_ADDR_RX_DATA:   rd_mux = rx_data;
      default:                 rd_mux = '0;
    endcase
  end

  // Zero outside a read access
  assign prdata = rd_en ? rd_mux : '0;

endmodule

// File: src/apb_uart_rx.sv
// ******************************
// APB UART receiver top
// Bit timer, frame controller and APB registers
// ******************************
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module apb_uart_rx
(
  input  logic                       tb_clk,
  input  logic                       rst_n,
  input  logic                       serial_in,
  input  logic                       psel,
  input  logic [`UART_RX_ADDR_W-1:0] paddr,
  input  logic                       penable,
  input  logic                       pwrite,
  input  uart_rx_pkg::rx_word_t       pwdata,
  output uart_rx_pkg::rx_word_t       prdata,
  output logic                       pslverr
);

  import uart_rx_pkg::*;

  // Timer to frame controller
  logic       line;
  logic       start_edge;
  logic       sample;
  logic       timer_run;
  // Frame controller to registers
  logic       frame_done;
  rx_word_t   frame_data;
  logic       frame_err;
  // Configuration
  rx_period_t bit_period;
  rx_size_t   data_size;

  // ******************************
  // Serial side
  // ******************************
  rx_bit_timer u_bit_timer
  (
    .tb_clk     (tb_clk),
    .rst_n      (rst_n),
    .serial_in  (serial_in),
    .timer_run  (timer_run),
    .bit_period (bit_period),
    .line       (line),
    .start_edge (start_edge),
    .sample     (sample)
  );

  rx_frame_ctrl u_frame_ctrl
  (
    .tb_clk     (tb_clk),
    .rst_n      (rst_n),
    .line       (line),
    .start_edge (start_edge),
    .sample     (sample),
    .data_size  (data_size),
    .timer_run  (timer_run),
    .frame_done (frame_done),
    .frame_data (frame_data),
    .frame_err  (frame_err)
  );

  // ******************************
  // Bus side
  // ******************************
  apb_rx_regs u_regs
  (
    .tb_clk     (tb_clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .paddr      (paddr),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .frame_done (frame_done),
    .frame_data (frame_data),
    .frame_err  (frame_err),
    .bit_period (bit_period),
    .data_size  (data_size)
  );

endmodule

// File: verification/apb_uart_rx_checker.sv
// ******************************
// APB register block checker
// Bus phase, frame pulse and data-ready rules
// ******************************
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module apb_uart_rx_checker
(
  input logic                       tb_clk,
  input logic                       rst_n,
  input logic                       psel,
  input logic                       penable,
  input logic                       pwrite,
  input logic [`UART_RX_ADDR_W-1:0] paddr,
  input logic                       pslverr,
  input logic                       frame_done,
  input logic                       data_ready
);

  // Failure tallies per property
  int pslverr_fails = 0;
  int done_fails = 0;
  int ready_fails = 0;

  logic rd_data_access;

  // Read access to the received data word
  assign rd_data_access = psel & penable & ~pwrite & (paddr == `UART_RX_ADDR_RX_DATA);

  // Error response only while psel and penable are both high
  pslverr_phase: assert property (@(posedge tb_clk) disable iff (!rst_n)
    pslverr |-> (psel && penable))
  else
  begin
    $error("pslverr high outside the APB access phase");
    pslverr_fails = pslverr_fails + 1;
  end

  // Frame pulse lasts one cycle
  done_single: assert property (@(posedge tb_clk) disable iff (!rst_n)
    frame_done |=> !frame_done)
  else
  begin
    $error("frame_done high for two cycles in a row");
    done_fails = done_fails + 1;
  end

  // Data ready drops only at the edge ending a data read
  ready_clear: assert property (@(posedge tb_clk) disable iff (!rst_n)
    $fell(data_ready) |-> $past(rd_data_access))
  else
  begin
    $error("data ready fell without a read of the data register");
    ready_fails = ready_fails + 1;
  end

endmodule

bind apb_rx_regs apb_uart_rx_checker u_checker
(
  .tb_clk     (tb_clk),
  .rst_n      (rst_n),
  .psel       (psel),
  .penable    (penable),
  .pwrite     (pwrite),
  .paddr      (paddr),
  .pslverr    (pslverr),
  .frame_done (frame_done),
  .data_ready (data_ready)
);

// File: verification/tb_apb_uart_rx.sv
// ******************************
// APB UART receiver testbench
// Register access, random frames, overrun, framing
// error and unmapped addresses against a model
// ******************************
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module tb_apb_uart_rx;

  import uart_rx_pkg::*;

  // Random frames plus overrun pair and bad stop frame
  localparam int NUM_RANDOM     = 30;
  localparam int NUM_FRAMES     = NUM_RANDOM + 3;
  localparam int MAX_PERIOD     = 40;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 11 * MAX_PERIOD + 2000;

  logic                       tb_clk;
  logic                       rst_n;
  logic                       serial_in;
  logic                       psel;
  logic [`UART_RX_ADDR_W-1:0] paddr;
  logic                       penable;
  logic                       pwrite;
  rx_word_t                   pwdata;
  rx_word_t                   prdata;
  logic                       pslverr;

  int checks = 0;
  int errors = 0;
  int cycle_cnt = 0;
  int assert_fails;

  // Model of the register map and flags
  rx_period_t period_m;
  rx_size_t   size_m;
  rx_word_t   data_m;
  logic       ready_m;
  logic       overrun_m;
  logic       ferr_m;

  apb_uart_rx uut
  (
    .tb_clk    (tb_clk),
    .rst_n     (rst_n),
    .serial_in (serial_in),
    .psel      (psel),
    .paddr     (paddr),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pslverr   (pslverr)
  );

  // 4 ns clock
  initial tb_clk = 1'b0;
  always #2 tb_clk = ~tb_clk;

  // Run limit
  always @(posedge tb_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ******************************
  // Check and model helpers
  // ******************************
  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    checks = checks + 1;
    if (actual !== expected)
    begin
      errors = errors + 1;
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual,
               expected);
    end
  endtask

  // Addresses 5 and 7 are holes in the map
  function automatic logic unmapped(input logic [2:0] addr);
    return (addr == 3'd5) || (addr == 3'd7);
  endfunction

  function automatic rx_size_t clamp_size(input rx_word_t value);
    if (value < 8'd5)
      return 4'd5;
    else if (value > 8'd8)
      return 4'd8;
    else
      return value[3:0];
  endfunction

  function automatic void model_write(input logic [2:0] addr, input rx_word_t data);
    case (addr)
      3'd2: period_m[7:0] = data;
      // Only six bits above the low byte
      3'd3: period_m[13:8] = data[5:0];
      3'd4: size_m = clamp_size(data);
      default:
      begin
      end
    endcase
  endfunction

  function automatic rx_word_t expected_read(input logic [2:0] addr);
    case (addr)
      3'd0:    return {7'd0, ready_m};
      3'd1:    return {6'd0, overrun_m, ferr_m};
      3'd2:    return period_m[7:0];
      3'd3:    return {2'b00, period_m[13:8]};
      3'd4:    return {4'd0, size_m};
      3'd6:    return data_m;
      default: return 8'd0;
    endcase
  endfunction

  // ******************************
  // APB and serial drivers
  // ******************************
  task automatic apb_write(input logic [2:0] addr, input rx_word_t data);
    logic err;
    @(posedge tb_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge tb_clk);
    penable <= 1'b1;
    // Mid access phase, outputs settled
    @(negedge tb_clk);
    err = pslverr;
    @(posedge tb_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    check_value("pslverr", err, unmapped(addr));
    model_write(addr, data);
  endtask

  task automatic apb_read(input logic [2:0] addr, output rx_word_t data, output logic err);
    @(posedge tb_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge tb_clk);
    penable <= 1'b1;
    @(negedge tb_clk);
    data = prdata;
    err  = pslverr;
    @(posedge tb_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(input logic [2:0] addr, input string name);
    rx_word_t data;
    logic     err;
    apb_read(addr, data, err);
    check_value(name, data, expected_read(addr));
    check_value("pslverr", err, unmapped(addr));
    // Data read clears every flag
    if (addr == 3'd6)
    begin
      ready_m   = 1'b0;
      overrun_m = 1'b0;
      ferr_m    = 1'b0;
    end
  endtask

  task automatic configure(input rx_period_t period, input rx_word_t size);
    apb_write(3'd2, period[7:0]);
    apb_write(3'd3, {2'b00, period[13:8]});
    apb_write(3'd4, size);
  endtask

  task automatic drive_bit(input logic value, input int period);
    serial_in <= value;
    repeat (period) @(posedge tb_clk);
  endtask

  // Start bit, size_m data bits LSB first, stop bit
  task automatic send_frame(input rx_word_t word, input logic stop_bit);
    int period;
    int size;
    period = int'(period_m);
    size   = int'(size_m);
    @(posedge tb_clk);
    drive_bit(1'b0, period);
    for (int i = 0; i < size; i++)
    begin
      drive_bit(word[i], period);
    end
    drive_bit(stop_bit, period);
    serial_in <= 1'b1;
    repeat (2) @(posedge tb_clk);
    // Unread word is lost, data kept even with a bad stop bit
    overrun_m = overrun_m | ready_m;
    ready_m   = 1'b1;
    ferr_m    = ferr_m | ~stop_bit;
    data_m    = '0;
    for (int i = 0; i < size; i++)
    begin
      data_m[i] = word[i];
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************
  initial
  begin
    rx_word_t    rd;
    logic        err;
    logic [2:0]  addr;
    rx_word_t    data;
    rx_word_t    word;
    logic [2:0]  reset_addr [6];
    rx_word_t    reset_val [6];
    void'($urandom(38934));
    serial_in = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    rst_n     = 1'b0;
    period_m  = 14'd10;
    size_m    = 4'd8;
    data_m    = '0;
    ready_m   = 1'b0;
    overrun_m = 1'b0;
    ferr_m    = 1'b0;
    repeat (4) @(posedge tb_clk);
    rst_n <= 1'b1;
    @(posedge tb_clk);

    // Reset values of the whole map
    reset_addr = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd6};
    reset_val  = '{8'd0, 8'd0, 8'd10, 8'd0, 8'd8, 8'd0};
    for (int i = 0; i < 6; i++)
    begin
      apb_read(reset_addr[i], rd, err);
      check_value("prdata after reset", rd, reset_val[i]);
      check_value("pslverr", err, 1'b0);
    end

    // Config registers, with clamp and mask
    repeat (20)
    begin
      addr = 3'(2 + $urandom_range(2, 0));
      data = (addr == 3'd4) ? 8'($urandom_range(12, 0)) : 8'($urandom);
      apb_write(addr, data);
      read_check(3'd2, "period_lo");
      read_check(3'd3, "period_hi");
      read_check(3'd4, "data_size");
    end

    // Random frames, each read back
    repeat (NUM_RANDOM)
    begin
      configure(14'($urandom_range(MAX_PERIOD, 10)), 8'($urandom_range(8, 5)));
      send_frame(8'($urandom), 1'b1);
      read_check(3'd0, "data_sr");
      read_check(3'd1, "error_sr");
      read_check(3'd6, "rx_data");
      read_check(3'd0, "data_sr");
    end

    // Overrun, second word kept
    configure(14'($urandom_range(MAX_PERIOD, 10)), 8'($urandom_range(8, 5)));
    send_frame(8'($urandom), 1'b1);
    send_frame(8'($urandom), 1'b1);
    read_check(3'd1, "error_sr");
    read_check(3'd0, "data_sr");
    read_check(3'd6, "rx_data");
    read_check(3'd1, "error_sr");

    // Stop bit sampled low
    word = 8'($urandom);
    send_frame(word, 1'b0);
    read_check(3'd1, "error_sr");
    read_check(3'd6, "rx_data");
    read_check(3'd1, "error_sr");

    // Unmapped and read-only addresses
    read_check(3'd5, "prdata addr 5");
    read_check(3'd7, "prdata addr 7");
    apb_write(3'd5, 8'($urandom));
    apb_write(3'd7, 8'($urandom));
    apb_write(3'd0, 8'hff);
    apb_write(3'd1, 8'hff);
    apb_write(3'd6, 8'($urandom));
    read_check(3'd0, "data_sr");
    read_check(3'd1, "error_sr");
    read_check(3'd2, "period_lo");
    read_check(3'd3, "period_hi");
    read_check(3'd4, "data_size");
    read_check(3'd6, "rx_data");

    repeat (4) @(posedge tb_clk);
    assert_fails = uut.u_regs.u_checker.pslverr_fails + uut.u_regs.u_checker.done_fails +
                   uut.u_regs.u_checker.ready_fails;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: list.f
+incdir+src
src/uart_rx_pkg.sv
src/rx_bit_timer.sv
src/rx_frame_ctrl.sv
src/apb_rx_regs.sv
src/apb_uart_rx.sv
verification/apb_uart_rx_checker.sv
verification/tb_apb_uart_rx.sv

// File: run.sh
#!/bin/sh
# Build and run the APB UART receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_apb_uart_rx -Mdir obj_dir

./obj_dir/Vtb_apb_uart_rx +verilator+error+limit+1000 > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
